/* verilog/tart_bus_pkg.sv */
package tart_bus_pkg;

   // -------------------------------------------------------------------------
   // 8-bit bus between the SPI slave and its peripherals
   // -------------------------------------------------------------------------
   localparam int BUS_DATA_W = 8;
   localparam int BUS_ADDR_W = 7;                  // cmd byte minus the write flag

   typedef logic [BUS_DATA_W-1:0] bus_data_t;
   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

   // address map
   localparam bus_addr_t AQ_BASE  = 7'h00;         // 0x00..0x07, decoded on bits 6:3
   localparam bus_addr_t RST_ADDR = 7'h0F;

   // acquisition registers, offset within the window
   localparam logic [2:0] AQ_REG_CTRL = 3'd0;      // en 4, debug 3, delay 2:0
   localparam logic [2:0] AQ_REG_DATA = 3'd1;      // sample byte stream
   localparam logic [2:0] AQ_REG_FILL = 3'd2;      // samples in the buffer

   // soft reset length
   localparam int RST_CYCLES = 4;
   localparam int RST_CNT_W  = $clog2(RST_CYCLES + 1);
   typedef logic [RST_CNT_W-1:0] rst_cnt_t;

endpackage

/* verilog/tart_aq_pkg.sv */
package tart_aq_pkg;

   // -------------------------------------------------------------------------
   // capture path types and constants
   // -------------------------------------------------------------------------
   localparam int SAMPLE_W     = 24;               // one bit per antenna
   localparam int SAMPLE_BYTES = SAMPLE_W / 8;     // bytes per sample on the bus
   localparam int BUF_DEPTH    = 32;               // block buffer, samples
   localparam int TICK_PERIOD  = 6;                // fpga_clk cycles per sample

   typedef logic [SAMPLE_W-1:0]            sample_t;
   typedef logic [$clog2(BUF_DEPTH)-1:0]   buf_addr_t;
   typedef logic [$clog2(BUF_DEPTH):0]     fill_t;    // 0..BUF_DEPTH
   typedef logic [2:0]                     delay_t;   // sample phase in the tick

   // fill state machine
   typedef enum logic [1:0] {
      CAP_IDLE = 2'd0,                             // enable low
      CAP_FILL = 2'd1,                             // writing one sample per tick
      CAP_FULL = 2'd2                              // buffer done, wait for enable to drop
   } cap_state_t;

endpackage

/* verilog/spi_slave.sv */
`timescale 1ns/1ps

module spi_slave
   import tart_bus_pkg::*;
(
   input  logic      fpga_clk,
   input  logic      b_rst,
   input  logic      sck_i,
   input  logic      ssel_i,
   input  logic      mosi_i,
   output logic      miso_o,
   input  bus_data_t status_i,
   output logic      cyc_o,
   output logic      stb_o,
   output logic      we_o,
   output bus_addr_t adr_o,
   output bus_data_t dat_o,
   input  logic      ack_i,
   input  bus_data_t dat_i
);

   logic [2:0] sck_q;                              // 2-flop sync plus edge stage
   logic [1:0] ssel_q;
   logic [1:0] mosi_q;
   logic       sck_rise, sck_fall;
   logic       active;                             // synchronised ssel low
   logic       byte_done;
   logic [2:0] bit_cnt;
   logic [6:0] rx_sr;
   bus_data_t  rx_byte;
   bus_data_t  tx_sr;
   bus_data_t  nxt_byte;                           // data for the following byte
   logic       cmd_phase;                          // next byte is the command
   logic       load_pend;                          // reload tx on the next fall
   logic       ack_slot;                           // cycle where ack is due

   assign sck_rise  = sck_q[1] & ~sck_q[2];
   assign sck_fall  = ~sck_q[1] & sck_q[2];
   assign active    = ~ssel_q[1];
   assign rx_byte   = {rx_sr, mosi_q[1]};
   assign byte_done = active & sck_rise & (bit_cnt == 3'd7);
   assign miso_o    = tx_sr[7];                    // msb first

   // -------------------------------------------------------------------------
   // pin synchronisers
   // -------------------------------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         sck_q  <= 3'b000;
         ssel_q <= 2'b11;
         mosi_q <= 2'b00;
      end else begin
         sck_q  <= {sck_q[1:0], sck_i};
         ssel_q <= {ssel_q[0], ssel_i};
         mosi_q <= {mosi_q[0], mosi_i};
      end
   end

   // -------------------------------------------------------------------------
   // framing and bus master
   // -------------------------------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         bit_cnt   <= 3'd0;
         cmd_phase <= 1'b1;
         load_pend <= 1'b0;
         ack_slot  <= 1'b0;
         cyc_o     <= 1'b0;
         stb_o     <= 1'b0;
         we_o      <= 1'b0;
         adr_o     <= '0;
         tx_sr     <= 8'hFF;                       // miso idles high
      end else begin
         stb_o    <= 1'b0;                         // single-cycle strobe
         ack_slot <= stb_o;
         if (!active) begin
            bit_cnt   <= 3'd0;
            cmd_phase <= 1'b1;
            load_pend <= 1'b0;
            cyc_o     <= 1'b0;
            tx_sr     <= status_i;                 // first byte out is status
         end else begin
            if (sck_rise) begin
               bit_cnt <= bit_cnt + 3'd1;
            end
            if (byte_done) begin
               load_pend <= 1'b1;
               if (cmd_phase) begin
                  cmd_phase <= 1'b0;
                  cyc_o     <= 1'b1;
                  we_o      <= rx_byte[7];
                  adr_o     <= rx_byte[6:0];
                  stb_o     <= ~rx_byte[7];        // prefetch first read byte
               end else begin
                  stb_o     <= 1'b1;               // one access per data byte
               end
            end
            if (sck_fall) begin
               if (load_pend) begin
                  tx_sr     <= nxt_byte;
                  load_pend <= 1'b0;
               end else begin
                  tx_sr     <= {tx_sr[6:0], 1'b1};
               end
            end
         end
      end
   end

   // shift register and data path
   always_ff @(posedge fpga_clk) begin
      if (active && sck_rise) begin
         rx_sr <= rx_byte[6:0];
      end
      if (byte_done && !cmd_phase) begin
         dat_o <= rx_byte;                         // write data for this access
      end
      if (byte_done) begin
         nxt_byte <= 8'hFF;
      end else if (ack_slot) begin
         nxt_byte <= ack_i ? dat_i : 8'hFF;        // no ack means no peripheral
      end
   end

   a_stb_single : assert property (@(posedge fpga_clk) disable iff (b_rst)
      stb_o |-> cyc_o ##1 !stb_o)
      else $error("spi_slave: stb not a single-cycle strobe inside cyc");

endmodule

/* verilog/wb_reset.sv */
`timescale 1ns/1ps

module wb_reset
   import tart_bus_pkg::*;
(
   input  logic      fpga_clk,
   input  logic      b_rst,
   input  logic      stb_i,
   input  logic      we_i,
   input  bus_data_t dat_i,
   output logic      ack_o,
   output bus_data_t dat_o,
   output logic      soft_rst_o
);

   rst_cnt_t rst_cnt;                              // cycles of reset left
   logic     req;                                  // write with bit 0 seen
   logic     rst_busy;

   assign rst_busy   = rst_cnt != '0;
   assign soft_rst_o = b_rst | rst_busy;

   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         ack_o   <= 1'b0;
         req     <= 1'b0;
         rst_cnt <= '0;
      end else begin
         ack_o <= stb_i;
         req   <= stb_i & we_i & dat_i[0];
         if (req) begin
            rst_cnt <= rst_cnt_t'(RST_CYCLES);     // starts after the ack cycle
         end else if (rst_busy) begin
            rst_cnt <= rst_cnt - 1'b1;
         end
      end
   end

   // read back the reset-active flag
   always_ff @(posedge fpga_clk) begin
      if (stb_i) begin
         dat_o <= {7'b0000000, rst_busy};
      end
   end

   a_ack_timing : assert property (@(posedge fpga_clk) disable iff (b_rst)
      stb_i |=> ack_o)
      else $error("wb_reset: ack did not follow stb");

   a_rst_len : assert property (@(posedge fpga_clk) disable iff (b_rst)
      req |=> soft_rst_o [*RST_CYCLES])
      else $error("wb_reset: soft reset shorter than RST_CYCLES");

endmodule

/* verilog/tart_aquire.sv */
`timescale 1ns/1ps

module tart_aquire
   import tart_bus_pkg::*;
   import tart_aq_pkg::*;
(
   input  logic       fpga_clk,
   input  logic       rst_i,
   input  logic       stb_i,
   input  logic       we_i,
   input  logic [2:0] adr_i,
   input  bus_data_t  dat_i,
   output logic       ack_o,
   output bus_data_t  dat_o,
   output logic       aq_en_o,
   output logic       aq_debug_o,
   output delay_t     aq_delay_o,
   output logic       rd_next_o,
   input  sample_t    rd_data_i,
   input  fill_t      fill_i,
   input  logic       full_i
);

   logic [1:0] byte_sel;                           // 0 lsb, 1 mid, 2 msb
   logic       last_byte;
   logic       ctrl_wr;
   logic       data_rd;
   bus_data_t  rd_byte;

   assign ctrl_wr   = stb_i & we_i & (adr_i == AQ_REG_CTRL);
   assign data_rd   = stb_i & ~we_i & (adr_i == AQ_REG_DATA);
   assign last_byte = byte_sel == 2'(SAMPLE_BYTES - 1);

   always_comb begin
      case (byte_sel)
         2'd0:    rd_byte = rd_data_i[7:0];
         2'd1:    rd_byte = rd_data_i[15:8];
         default: rd_byte = rd_data_i[23:16];
      endcase
   end

   // -------------------------------------------------------------------------
   // control register and byte sequencing
   // -------------------------------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (rst_i) begin
         ack_o      <= 1'b0;
         rd_next_o  <= 1'b0;
         aq_en_o    <= 1'b0;
         aq_debug_o <= 1'b0;
         aq_delay_o <= '0;
         byte_sel   <= 2'd0;
      end else begin
         ack_o     <= stb_i;                       // every register answers
         rd_next_o <= data_rd & last_byte;         // sample consumed
         if (ctrl_wr) begin
            aq_en_o    <= dat_i[4];
            aq_debug_o <= dat_i[3];
            aq_delay_o <= dat_i[2:0];
            byte_sel   <= 2'd0;                    // restart on lsb
         end else if (data_rd) begin
            byte_sel   <= last_byte ? 2'd0 : byte_sel + 2'd1;
         end
      end
   end

   // read data, valid in the ack cycle
   always_ff @(posedge fpga_clk) begin
      if (stb_i) begin
         case (adr_i)
            AQ_REG_CTRL: dat_o <= {full_i, 2'b00, aq_en_o, aq_debug_o, aq_delay_o};
            AQ_REG_DATA: dat_o <= rd_byte;
            AQ_REG_FILL: dat_o <= {2'b00, fill_i};
            default:     dat_o <= '0;              // unused offsets
         endcase
      end
   end

   a_rd_next_src : assert property (@(posedge fpga_clk) disable iff (rst_i)
      rd_next_o |-> $past(data_rd))
      else $error("tart_aquire: rd_next without a data read");

endmodule

/* verilog/aq_capture.sv */
`timescale 1ns/1ps

module aq_capture
   import tart_aq_pkg::*;
(
   input  logic    fpga_clk,
   input  logic    rst_i,
   input  sample_t antenna_i,
   input  logic    aq_en_i,
   input  logic    aq_debug_i,
   input  delay_t  aq_delay_i,
   input  logic    rd_next_i,
   output sample_t rd_data_o,
   output fill_t   fill_o,
   output logic    full_o
);

   cap_state_t state;
   delay_t     tick_cnt;                           // 0..TICK_PERIOD-1
   delay_t     phase;
   logic       tick;
   logic       wr_en;
   sample_t    antenna_q;                          // io register
   sample_t    fake_q;                             // debug counter
   sample_t    wr_data;
   buf_addr_t  rd_ptr;
   sample_t    mem [BUF_DEPTH];

   // delays past the last count clamp to it
   assign phase   = (aq_delay_i > delay_t'(TICK_PERIOD - 1)) ?
                    delay_t'(TICK_PERIOD - 1) : aq_delay_i;
   assign tick    = tick_cnt == phase;
   assign wr_en   = (state == CAP_FILL) & tick;
   assign wr_data = aq_debug_i ? fake_q : antenna_q;
   assign full_o  = state == CAP_FULL;

   // -------------------------------------------------------------------------
   // tick counter and fill FSM
   // -------------------------------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (rst_i) begin
         tick_cnt <= '0;
         state    <= CAP_IDLE;
         fill_o   <= '0;
         rd_ptr   <= '0;
         fake_q   <= '0;
      end else begin
         tick_cnt <= (tick_cnt == delay_t'(TICK_PERIOD - 1)) ? '0 : tick_cnt + 1'b1;
         if (rd_next_i) begin
            rd_ptr <= rd_ptr + 1'b1;               // wraps at BUF_DEPTH
         end
         if (!aq_en_i) begin
            state  <= CAP_IDLE;
            fake_q <= '0;
         end else begin
            case (state)
               CAP_IDLE: begin                     // enable just rose
                  state  <= CAP_FILL;
                  fill_o <= '0;
                  rd_ptr <= '0;
               end
               CAP_FILL: if (tick) begin
                  fake_q <= fake_q + 1'b1;
                  fill_o <= fill_o + 1'b1;
                  if (fill_o == fill_t'(BUF_DEPTH - 1)) begin
                     state <= CAP_FULL;
                  end
               end
               default: state <= CAP_FULL;         // hold until enable drops
            endcase
         end
      end
   end

   // block buffer
   always_ff @(posedge fpga_clk) begin
      antenna_q <= antenna_i;
      if (wr_en) begin
         mem[buf_addr_t'(fill_o)] <= wr_data;
      end
      rd_data_o <= mem[rd_ptr];
   end

   a_no_wr_full : assert property (@(posedge fpga_clk) disable iff (rst_i)
      full_o |-> fill_o == fill_t'(BUF_DEPTH))
      else $error("aq_capture: fill count not BUF_DEPTH while full");

endmodule

/* verilog/tart_top.sv */
`timescale 1ns/1ps

module tart_top
   import tart_bus_pkg::*;
   import tart_aq_pkg::*;
(
   input  logic    fpga_clk,
   input  logic    b_rst,
   input  logic    spi_sck_i,
   input  logic    spi_ssel_i,
   input  logic    spi_mosi_i,
   output logic    spi_miso_o,
   input  sample_t antenna_i,
   output logic    led_o
);

   bus_data_t b_drx, b_dtx;                        // master out, master in
   bus_addr_t b_adr;
   logic      b_cyc, b_stb, b_we, b_ack;
   bus_data_t r_drx, a_drx;
   logic      r_stb, r_ack, r_sel;                 // reset handler
   logic      a_stb, a_ack, a_sel;                 // acquisition controller
   bus_data_t status;
   logic      soft_rst;
   logic      aq_en, aq_debug, rd_next, full;
   delay_t    aq_delay;
   sample_t   rd_data;
   fill_t     fill;

   // -------------------------------------------------------------------------
   // address decode and read return
   // -------------------------------------------------------------------------
   assign r_stb  = b_cyc & b_stb & (b_adr == RST_ADDR);
   assign a_stb  = b_cyc & b_stb & (b_adr[6:3] == AQ_BASE[6:3]);
   assign b_ack  = r_ack | a_ack;
   assign b_dtx  = r_sel ? r_drx : (a_sel ? a_drx : 8'hFF);
   assign status = {1'b1, full, aq_en, 5'b00000};
   assign led_o  = full;                           // data ready to read

   // keep the select from stb until ack
   always_ff @(posedge fpga_clk) begin
      if (b_rst) begin
         r_sel <= 1'b0;
         a_sel <= 1'b0;
      end else begin
         r_sel <= r_sel ? (!r_ack || r_stb) : r_stb;
         a_sel <= a_sel ? (!a_ack || a_stb) : a_stb;
      end
   end

   spi_slave u_spi (
      .fpga_clk (fpga_clk),   .b_rst  (b_rst),
      .sck_i    (spi_sck_i),  .ssel_i (spi_ssel_i), .mosi_i (spi_mosi_i),
      .miso_o   (spi_miso_o), .status_i (status),
      .cyc_o    (b_cyc),      .stb_o  (b_stb),      .we_o   (b_we),
      .adr_o    (b_adr),      .dat_o  (b_drx),
      .ack_i    (b_ack),      .dat_i  (b_dtx)
   );

   wb_reset u_rst (
      .fpga_clk (fpga_clk), .b_rst (b_rst),
      .stb_i    (r_stb),    .we_i  (b_we),  .dat_i (b_drx),
      .ack_o    (r_ack),    .dat_o (r_drx), .soft_rst_o (soft_rst)
   );

   tart_aquire u_aq (
      .fpga_clk   (fpga_clk), .rst_i    (soft_rst),
      .stb_i      (a_stb),    .we_i     (b_we),     .adr_i (b_adr[2:0]),
      .dat_i      (b_drx),    .ack_o    (a_ack),    .dat_o (a_drx),
      .aq_en_o    (aq_en),    .aq_debug_o (aq_debug), .aq_delay_o (aq_delay),
      .rd_next_o  (rd_next),  .rd_data_i  (rd_data),
      .fill_i     (fill),     .full_i     (full)
   );

   aq_capture u_cap (
      .fpga_clk   (fpga_clk), .rst_i      (soft_rst), .antenna_i (antenna_i),
      .aq_en_i    (aq_en),    .aq_debug_i (aq_debug), .aq_delay_i (aq_delay),
      .rd_next_i  (rd_next),  .rd_data_o  (rd_data),
      .fill_o     (fill),     .full_o     (full)
   );

endmodule

/* test/tart_checker.sv */
`timescale 1ns/1ps

module tart_checker
   import tart_bus_pkg::*;
   import tart_aq_pkg::*;
(
   input  logic      fpga_clk,
   input  logic      sck_i,
   input  logic      ssel_i,
   input  logic      miso_i,
   input  logic      led_i,
   input  int        row_i,
   input  bus_data_t status_i,                     // expected first miso byte
   input  logic      data_chk_i,                   // compare the data bytes
   input  sample_t   base_i,                       // sample behind data byte 0
   input  logic      step_i,                       // sample +1 every 3 bytes
   input  logic      led_chk_i,
   input  logic      led_exp_i,
   input  logic      done_i,                       // row finished, one cycle
   output int        tests_o,
   output int        failed_o,
   output int        errors_o
);

   logic      sck_d;
   bus_data_t shift;
   int        bit_n;
   int        byte_n;                              // byte within the frame
   int        seen;                                // bytes in this row
   int        row_errs;

   // data byte k comes from sample k/3, lsb first
   function automatic bus_data_t expect_byte(input int k);
      sample_t s;
      s = base_i + (step_i ? k / 3 : 0);
      return s[8 * (k % 3) +: 8];
   endfunction

   task automatic flag_error(input string msg);
      $display("[ERROR] %0t ns: test %0d %s", $time, row_i, msg);
      row_errs = row_errs + 1;
      errors_o = errors_o + 1;
   endtask

   initial begin
      sck_d    = 1'b0;
      shift    = '0;
      bit_n    = 0;
      byte_n   = 0;
      seen     = 0;
      row_errs = 0;
      tests_o  = 0;
      failed_o = 0;
      errors_o = 0;
   end

   // ------------------------------------------------------------------------
   // miso capture on sampled sck rises
   // ------------------------------------------------------------------------
   always @(posedge fpga_clk) begin
      if (ssel_i) begin
         bit_n  = 0;                               // frame closed
         byte_n = 0;
      end else if (sck_i && !sck_d) begin
         shift = {shift[6:0], miso_i};             // msb first
         bit_n = bit_n + 1;
         if (bit_n == 8) begin
            if (byte_n == 0) begin
               if (shift !== status_i) begin
                  flag_error($sformatf("status byte 0x%02h, expected 0x%02h",
                                       shift, status_i));
               end
            end else if (data_chk_i && shift !== expect_byte(byte_n - 1)) begin
               flag_error($sformatf("data byte %0d is 0x%02h, expected 0x%02h",
                                    byte_n - 1, shift, expect_byte(byte_n - 1)));
            end
            bit_n  = 0;
            byte_n = byte_n + 1;
            seen   = seen + 1;
         end
      end
      sck_d = sck_i;
      if (done_i) begin
         if (led_chk_i && led_i !== led_exp_i) begin
            flag_error($sformatf("led_o is %b, expected %b", led_i, led_exp_i));
         end
         tests_o = tests_o + 1;
         if (row_errs != 0) begin
            failed_o = failed_o + 1;
         end
         $display("test %0d: %0d bytes, %0d errors, %s", row_i, seen, row_errs,
                  (row_errs == 0) ? "ok" : "mismatch");
         row_errs = 0;
         seen     = 0;
      end
   end

endmodule

/* test/tb_tart.sv */
`timescale 1ns/1ps

module tb_tart
   import tart_bus_pkg::*;
   import tart_aq_pkg::*;
();

   localparam int HALF = 10;                       // sck half period, fpga_clk cycles

   typedef struct packed {
      logic       we;
      bus_addr_t  adr;
      logic [7:0] cnt;                             // data bytes after the command
      bus_data_t  wdat;
      sample_t    ant;                             // held on antenna_i
      bus_data_t  status;                          // expected status byte
      sample_t    base;                            // expected sample, data byte 0
      logic       step;
      logic       wait_led;                        // wait for a full buffer first
      logic [1:0] led;                             // 0 low, 1 high, 2 not checked
   } row_t;

   logic      fpga_clk;
   logic      b_rst;
   logic      sck, ssel, mosi, miso, led;
   sample_t   antenna;
   logic      done;
   int        row_idx;
   row_t      cur;
   row_t      table_q[$];
   int        n_tests, n_failed, n_errors;
   integer    seed;
   int        cycles = 0;
   int        limit;

   tart_top DUT (
      .fpga_clk   (fpga_clk), .b_rst      (b_rst),
      .spi_sck_i  (sck),      .spi_ssel_i (ssel),   .spi_mosi_i (mosi),
      .spi_miso_o (miso),     .antenna_i  (antenna), .led_o     (led)
   );

   tart_checker u_chk (
      .fpga_clk   (fpga_clk),           .sck_i     (sck),       .ssel_i (ssel),
      .miso_i     (miso),               .led_i     (led),       .row_i  (row_idx),
      .status_i   (cur.status),         .data_chk_i (!cur.we),
      .base_i     (cur.base),           .step_i    (cur.step),
      .led_chk_i  (cur.led != 2'd2),    .led_exp_i (cur.led[0]), .done_i (done),
      .tests_o    (n_tests),            .failed_o  (n_failed),  .errors_o (n_errors)
   );

   initial begin
      fpga_clk = 1'b0;
      forever #10 fpga_clk = ~fpga_clk;            // 50 MHz
   end

   // run limit from the total spi traffic
   always @(posedge fpga_clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout: run still busy after %0d cycles", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge fpga_clk);
      #2;                                          // drive just after the edge
   endtask

   // mode 0, host shifts on the falling edge
   task automatic spi_xfer(input bus_data_t cmd, input int n, input bus_data_t wdat);
      bus_data_t tx;
      ssel = 1'b0;
      for (int b = 0; b <= n; b++) begin
         tx = (b == 0) ? cmd : wdat;
         for (int i = 7; i >= 0; i--) begin
            mosi = tx[i];
            wait_cycles(HALF);
            sck = 1'b1;
            wait_cycles(HALF);
            sck = 1'b0;
         end
      end
      wait_cycles(HALF);
      ssel = 1'b1;
      wait_cycles(HALF);                           // gap so the frame resets
   endtask

   task automatic add_row(input logic we, input bus_addr_t adr, input int cnt,
                          input bus_data_t wdat, input sample_t ant, input bus_data_t status,
                          input sample_t base, input logic step, input logic wait_led,
                          input logic [1:0] led);
      row_t r;
      r.we       = we;
      r.adr      = adr;
      r.cnt      = cnt[7:0];
      r.wdat     = wdat;
      r.ant      = ant;
      r.status   = status;
      r.base     = base;
      r.step     = step;
      r.wait_led = wait_led;
      r.led      = led;
      table_q.push_back(r);
   endtask

   task automatic apply_row();
      if (cur.wait_led) begin
         while (led !== 1'b1) begin
            wait_cycles(1);
         end
      end
      spi_xfer({cur.we, cur.adr}, cur.cnt, cur.wdat);
      done = 1'b1;                                 // checker closes the row
      wait_cycles(1);
      done = 1'b0;
      wait_cycles(2);
   endtask

   // ------------------------------------------------------------------------
   // stimulus table and main loop
   // ------------------------------------------------------------------------
   initial begin
      logic [31:0] rnd;
      bus_data_t   d1, d2, full_cnt;
      sample_t     ant;
      bus_addr_t   ctrl, data, fill;
      int          nbytes;
      b_rst   = 1'b1;
      sck     = 1'b0;
      ssel    = 1'b1;
      mosi    = 1'b0;
      antenna = '0;
      done    = 1'b0;
      row_idx = 0;
      cur     = '0;
      seed    = 32'h847dcf43;
      rnd     = $random(seed);
      d1      = {5'b00000, rnd[2:0]};              // sample phases
      rnd     = $random(seed);
      d2      = {5'b00000, rnd[2:0]};
      rnd     = $random(seed);
      ant     = rnd[23:0];
      full_cnt = BUF_DEPTH;
      ctrl    = AQ_BASE + AQ_REG_CTRL;
      data    = AQ_BASE + AQ_REG_DATA;
      fill    = AQ_BASE + AQ_REG_FILL;

      // we adr cnt wdat ant status base step wait led
      add_row(0, ctrl, 1, 8'h00, 0, 8'h80, 24'h0, 0, 0, 0);          // after reset
      add_row(1, ctrl, 1, 8'h18 | d1, 0, 8'h80, 24'h0, 0, 0, 2);     // en + debug
      add_row(0, fill, 1, 8'h00, 0, 8'hE0, {3{full_cnt}}, 0, 1, 1);
      add_row(0, data, BUF_DEPTH * SAMPLE_BYTES, 8'h00, 0, 8'hE0, 24'h0, 1, 0, 1);
      add_row(1, ctrl, 1, 8'h00, ant, 8'hE0, 24'h0, 0, 0, 0);        // re-arm
      add_row(1, ctrl, 1, 8'h10 | d2, ant, 8'h80, 24'h0, 0, 0, 2);   // real antenna
      add_row(0, fill, 1, 8'h00, ant, 8'hE0, {3{full_cnt}}, 0, 1, 1);
      add_row(0, data, BUF_DEPTH * SAMPLE_BYTES, 8'h00, ant, 8'hE0, ant, 0, 0, 1);
      add_row(0, 7'h40, 1, 8'h00, ant, 8'hE0, 24'hFFFFFF, 0, 0, 1);  // unmapped
      add_row(1, RST_ADDR, 1, 8'h01, ant, 8'hE0, 24'h0, 0, 0, 0);    // soft reset
      add_row(0, ctrl, 1, 8'h00, ant, 8'h80, 24'h0, 0, 0, 0);

      nbytes = 0;
      for (int i = 0; i < table_q.size(); i++) begin
         nbytes = nbytes + table_q[i].cnt + 1;
      end
      limit = nbytes * 200 + 5000;

      repeat (5) @(posedge fpga_clk);
      #2;
      b_rst = 1'b0;
      wait_cycles(4);
      for (int i = 0; i < table_q.size(); i++) begin
         row_idx = i;
         cur     = table_q[i];
         antenna = cur.ant;
         apply_row();
      end

      wait_cycles(4);
      $display("tests run %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
      if (n_failed == 0 && n_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* verilog.f */
verilog/tart_bus_pkg.sv
verilog/tart_aq_pkg.sv
verilog/spi_slave.sv
verilog/wb_reset.sv
verilog/tart_aquire.sv
verilog/aq_capture.sv
verilog/tart_top.sv
test/tart_checker.sv
test/tb_tart.sv

/* Bender.yml */
package:
  name: tart_capture

sources:
  # receiver control and capture core
  - verilog/tart_bus_pkg.sv
  - verilog/tart_aq_pkg.sv
  - verilog/spi_slave.sv
  - verilog/wb_reset.sv
  - verilog/tart_aquire.sv
  - verilog/aq_capture.sv
  - verilog/tart_top.sv
  # simulation only
  - target: test
    files:
      - test/tart_checker.sv
      - test/tb_tart.sv
